// ==== src.f ====
memPkg.sv
memCtrl.sv
fetchUnit.sv
instQueue.sv
memTop.sv
ramModel.sv
tbMemTop.sv

// ==== tbMemTop.sv ====
`timescale 1ns/1ps

module tbMemTop;
    import memPkg::*;

    localparam int NumRounds = 30;
    localparam logic [AddrWidth-1:0] DataBase = 32'h300;
    // fetch addresses stay below the data area
    localparam logic [AddrWidth-1:0] PcLimit = 32'h280;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioFull;
    dataReq               dataIn;
    dataRsp               dataOut;
    ramBus                ram;
    logic [ByteWidth-1:0] ramRdata;
    logic                 jumpEn;
    logic [AddrWidth-1:0] jumpPc;
    logic                 issuePop;
    logic                 issueValid;
    instEntry             issueEntry;

    // reference copy of the RAM contents
    logic [ByteWidth-1:0] image [1024];
    logic [AddrWidth-1:0] expPc;
    int                   popCount;
    int                   waitCnt;
    int                   writeCnt;
    int                   reqBytes;
    int                   expLat;
    logic                 fetchSeen;
    logic                 active;
    logic                 stress;
    logic                 stressOn;
    int                   holdLeft;
    logic                 holdIo;

    memTop dut0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .ioFull     (ioFull),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .ram        (ram),
        .ramRdata   (ramRdata),
        .jumpEn     (jumpEn),
        .jumpPc     (jumpPc),
        .issuePop   (issuePop),
        .issueValid (issueValid),
        .issueEntry (issueEntry)
    );

    ramModel ram0 (
        .clk   (clk),
        .ram   (ram),
        .rdata (ramRdata)
    );

    always #20 clk = ~clk;

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        stopWithFailure($sformatf("MISMATCH %s: expected 0x%08h, actual 0x%08h",
                                  name, expected, actual));
    endtask

    function automatic int byteCount(input accessLen len);
        case (len)
            len1:    return 1;
            len2:    return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian and zero-extended
    function automatic logic [DataWidth-1:0] imageValue(input logic [AddrWidth-1:0] addr,
                                                        input int n);
        logic [DataWidth-1:0] v;
        logic [AddrWidth-1:0] a;
        v = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + i;
            v[8*i +: 8] = image[a[9:0]];
        end
        return v;
    endfunction

    task automatic dataAccess(input memCmd cmd, input accessLen len,
                              input logic [AddrWidth-1:0] addr,
                              input logic [DataWidth-1:0] wdata);
        logic [AddrWidth-1:0] a;
        repeat ($urandom % 3) @(posedge clk);
        @(posedge clk);
        #2;
        dataIn = '{en: 1'b1, cmd: cmd, len: len, addr: addr, wdata: wdata};
        @(posedge clk);
        while (!dataOut.done) begin
            @(posedge clk);
        end
        if (cmd == cmdStore) begin
            for (int i = 0; i < byteCount(len); i++) begin
                a = addr + i;
                image[a[9:0]] = wdata[8*i +: 8];
            end
        end
        #2;
        dataIn.en = 1'b0;
    endtask

    // check every honoured pop on the issue side
    always @(posedge clk) begin
        if (rst) begin
            expPc = '0;
            popCount = 0;
        end else if (jumpEn) begin
            expPc = jumpPc;
        end else if (issuePop && issueValid) begin
            assert (issueEntry.pc == expPc)
                else reportMismatch("fetch pc", expPc, issueEntry.pc);
            assert (issueEntry.inst == imageValue(expPc, 4))
                else reportMismatch("fetch inst", imageValue(expPc, 4), issueEntry.inst);
            expPc = expPc + 4;
            popCount++;
        end
    end

    // checks for the one open data request
    always @(posedge clk) begin
        if (rst || !dataIn.en) begin
            waitCnt = 0;
            writeCnt = 0;
            fetchSeen = 1'b0;
        end else begin
            reqBytes = byteCount(dataIn.len);
            if (ram.addr < DataBase) begin
                fetchSeen = 1'b1;
            end
            if (ram.rw) begin
                assert (ram.addr == dataIn.addr + writeCnt)
                    else reportMismatch("store address", dataIn.addr + writeCnt, ram.addr);
                assert (ram.wdata == dataIn.wdata[8*writeCnt +: 8])
                    else reportMismatch("store byte", dataIn.wdata[8*writeCnt +: 8], ram.wdata);
                writeCnt++;
            end
            if (dataOut.done) begin
                expLat = (dataIn.cmd == cmdStore) ? reqBytes : reqBytes + 1;
                // idle controller with no fetch in the way
                if (!fetchSeen && !stressOn) begin
                    assert (waitCnt == expLat)
                        else reportMismatch("done latency", expLat, waitCnt);
                end
                // a fetch in flight costs 5 cycles plus its done cycle
                assert (waitCnt <= expLat + 6)
                    else reportMismatch("priority wait bound", expLat + 6, waitCnt);
                if (dataIn.cmd == cmdStore) begin
                    assert (ram.rw) else stopWithFailure("store done without its last write");
                    assert (writeCnt == reqBytes)
                        else reportMismatch("store byte count", reqBytes, writeCnt);
                end else begin
                    assert (dataOut.rdata == imageValue(dataIn.addr, reqBytes))
                        else reportMismatch("load data", imageValue(dataIn.addr, reqBytes),
                                            dataOut.rdata);
                end
            end else if (rdy && !ioFull) begin
                waitCnt++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (!rdy || ioFull) |-> !ram.rw && !dataOut.done)
        else stopWithFailure("a write or done appeared while the controller was held");

    assert property (@(posedge clk) disable iff (rst)
        ram.rw |-> dataIn.en && dataIn.cmd == cmdStore)
        else stopWithFailure("RAM write without a store request");

    assert property (@(posedge clk) disable iff (rst)
        jumpEn |=> !issueValid)
        else stopWithFailure("issueValid stayed high after a jump");

    // pops, jumps and hold windows
    always @(posedge clk) begin
        active = !rst;
        stress = stressOn;
        #2;
        if (active) begin
            jumpEn = 1'b0;
            issuePop = 1'b0;
            if (expPc > PcLimit || (stress && $urandom % 48 == 0)) begin
                jumpEn = 1'b1;
                jumpPc = ($urandom % 128) * 4;
            end else begin
                // slow pops in the first half let the queue fill up
                issuePop = stress ? ($urandom % 3) != 0 : ($urandom % 16) == 0;
            end
            if (holdLeft > 0) begin
                holdLeft--;
            end else if (stress && $urandom % 12 == 0) begin
                holdLeft = 1 + $urandom % 4;
                holdIo = ($urandom % 2) != 0;
            end
            rdy = !(holdLeft > 0 && !holdIo);
            ioFull = holdLeft > 0 && holdIo;
        end
    end

    initial begin
        repeat (NumRounds * 3 * 40 + 200) @(posedge clk);
        stopWithFailure("watchdog expired, the run hung");
    end

    initial begin
        logic [AddrWidth-1:0] addr;
        accessLen             len;
        void'($urandom(25179));
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioFull = 1'b0;
        issuePop = 1'b0;
        jumpEn = 1'b0;
        jumpPc = '0;
        dataIn = '0;
        stressOn = 1'b0;
        holdLeft = 0;
        holdIo = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            image[i] = ByteWidth'((i * 29) ^ (i >> 5));
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < NumRounds; r++) begin
            // second half adds holds and random jumps
            if (r == NumRounds / 2) begin
                stressOn = 1'b1;
            end
            addr = DataBase + ($urandom % 253);
            case ($urandom % 3)
                0:       len = len1;
                1:       len = len2;
                default: len = len4;
            endcase
            dataAccess(cmdLoad, len, addr, '0);
            dataAccess(cmdStore, len, addr, $urandom);
            dataAccess(cmdLoad, len4, addr, '0);
        end
        if (popCount == 0) begin
            stopWithFailure("no instruction was ever issued");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// ==== ramModel.sv ====
`timescale 1ns/1ps

module ramModel (
    input  logic                         clk,
    input  memPkg::ramBus                ram,
    output logic [memPkg::ByteWidth-1:0] rdata
);
    import memPkg::*;

    // 1 KiB, upper address bits ignored
    logic [ByteWidth-1:0] mem [1024];

    // preload pattern from the full 10-bit index
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = ByteWidth'((i * 29) ^ (i >> 5));
        end
    end

    // one cycle read latency
    always @(posedge clk) begin
        if (ram.rw) begin
            mem[ram.addr[9:0]] <= ram.wdata;
        end
        rdata <= mem[ram.addr[9:0]];
    end

endmodule

// ==== memTop.sv ====
`timescale 1ns/1ps

module memTop (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          ioFull,
    input  memPkg::dataReq                dataIn,
    output memPkg::dataRsp                dataOut,
    output memPkg::ramBus                 ram,
    input  logic [memPkg::ByteWidth-1:0]  ramRdata,
    input  logic                          jumpEn,
    input  logic [memPkg::AddrWidth-1:0]  jumpPc,
    input  logic                          issuePop,
    output logic                          issueValid,
    output memPkg::instEntry              issueEntry
);
    import memPkg::*;

    fetchReq  fetchRequest;
    fetchRsp  fetchResponse;
    instEntry pushEntry;
    logic     push;
    logic     queueFull;

    fetchUnit fetchUnit0 (
        .clk       (clk),
        .rst       (rst),
        .jumpEn    (jumpEn),
        .jumpPc    (jumpPc),
        .queueFull (queueFull),
        .fetchOut  (fetchRequest),
        .fetchIn   (fetchResponse),
        .push      (push),
        .pushEntry (pushEntry)
    );

    // a jump flushes whatever was fetched down the old path
    instQueue instQueue0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (jumpEn),
        .push       (push),
        .pushEntry  (pushEntry),
        .pop        (issuePop),
        .full       (queueFull),
        .issueValid (issueValid),
        .issueEntry (issueEntry)
    );

    memCtrl memCtrl0 (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .ioFull   (ioFull),
        .dataIn   (dataIn),
        .dataOut  (dataOut),
        .fetchIn  (fetchRequest),
        .fetchOut (fetchResponse),
        .ram      (ram),
        .ramRdata (ramRdata)
    );

endmodule

// ==== instQueue.sv ====
`timescale 1ns/1ps

module instQueue (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             push,
    input  memPkg::instEntry pushEntry,
    input  logic             pop,
    output logic             full,
    output logic             issueValid,
    output memPkg::instEntry issueEntry
);
    import memPkg::*;

    instEntry                 entries [QueueDepth];
    logic [QueuePtrWidth-1:0] rdPtr;
    logic [QueuePtrWidth-1:0] wrPtr;
    logic [QueueCntWidth-1:0] count;
    logic                     doPush;
    logic                     doPop;

    assign full       = count == QueueCntWidth'(QueueDepth);
    assign issueValid = count != '0;
    assign doPush     = push && !full;
    assign doPop      = pop && issueValid;
    assign issueEntry = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushEntry;
        end
    end

    // fetch side must respect back-pressure
    assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          jumpEn,
    input  logic [memPkg::AddrWidth-1:0]  jumpPc,
    input  logic                          queueFull,
    output memPkg::fetchReq               fetchOut,
    input  memPkg::fetchRsp               fetchIn,
    output logic                          push,
    output memPkg::instEntry              pushEntry
);
    import memPkg::*;

    // next address to fetch
    logic [AddrWidth-1:0] pc;
    // address of the fetch in flight
    logic [AddrWidth-1:0] reqPc;
    logic                 busy;
    logic                 stale;

    assign fetchOut.en   = busy;
    assign fetchOut.addr = reqPc;

    // drop results of a fetch that a jump overtook
    assign push = fetchIn.done && busy && !stale && !jumpEn;

    assign pushEntry.pc   = reqPc;
    assign pushEntry.inst = fetchIn.inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= '0;
            busy  <= 1'b0;
            stale <= 1'b0;
        end else begin
            if (fetchIn.done) begin
                busy  <= 1'b0;
                stale <= 1'b0;
                if (!stale) begin
                    pc <= pc + AddrWidth'(WordBytes);
                end
            end else if (!busy && !queueFull && !jumpEn) begin
                busy <= 1'b1;
            end

            // jump overrides the pc update above
            if (jumpEn) begin
                pc <= jumpPc;
                if (busy && !fetchIn.done) begin
                    stale <= 1'b1;
                end
            end
        end
    end

    // captured as the request goes out, stable while busy
    always_ff @(posedge clk) begin
        if (!busy) begin
            reqPc <= pc;
        end
    end

endmodule

// ==== memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          ioFull,
    input  memPkg::dataReq                dataIn,
    output memPkg::dataRsp                dataOut,
    input  memPkg::fetchReq               fetchIn,
    output memPkg::fetchRsp               fetchOut,
    output memPkg::ramBus                 ram,
    input  logic [memPkg::ByteWidth-1:0]  ramRdata
);
    import memPkg::*;

    ctrlState              state;
    logic [StageWidth-1:0] stage;

    // latched request
    logic [AddrWidth-1:0]  baseAddr;
    accessLen              lenReg;
    // store data or load assembly
    logic [DataWidth-1:0]  wordBuf;

    logic                  hold;
    logic [StageWidth-1:0] lenBytes;
    logic [StageWidth-1:0] byteSel;
    logic [StageWidth-1:0] addrStage;
    logic [DataWidth-1:0]  loadWord;
    logic                  lastRead;
    logic                  lastWrite;

    assign hold     = !rdy || ioFull;
    assign lenBytes = lenReg;
    assign byteSel  = stage - 1'b1;

    // while held, put the previous byte address back on the bus
    // so the byte seen on resume is the one the stage expects
    assign addrStage = (hold && stage != '0) ? byteSel : stage;

    // byte stage-1 arrives now, merged little-endian into the buffer
    assign loadWord = wordBuf | (DataWidth'(ramRdata) << (ByteWidth * byteSel));

    assign lastRead  = stage == lenBytes;
    assign lastWrite = stage == lenBytes - 1'b1;

    always_comb begin
        ram.rw    = (state == stStore) && !hold;
        ram.addr  = baseAddr + AddrWidth'(addrStage);
        ram.wdata = ByteWidth'(wordBuf >> (ByteWidth * stage));
    end

    always_comb begin
        dataOut.done   = !hold && ((state == stLoad && lastRead) ||
                                   (state == stStore && lastWrite));
        dataOut.rdata  = loadWord;
        fetchOut.done  = !hold && state == stFetch && lastRead;
        fetchOut.inst  = loadWord;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            stage <= '0;
        end else if (!hold) begin
            case (state)
                stIdle: begin
                    // data port first
                    if (dataIn.en) begin
                        state <= (dataIn.cmd == cmdStore) ? stStore : stLoad;
                        stage <= '0;
                    end else if (fetchIn.en) begin
                        state <= stFetch;
                        stage <= '0;
                    end
                end
                stLoad, stFetch: begin
                    if (lastRead) begin
                        state <= stDone;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                stStore: begin
                    if (lastWrite) begin
                        state <= stDone;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                stDone: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if (state == stIdle) begin
                if (dataIn.en) begin
                    baseAddr <= dataIn.addr;
                    lenReg   <= dataIn.len;
                    wordBuf  <= (dataIn.cmd == cmdStore) ? dataIn.wdata : '0;
                end else if (fetchIn.en) begin
                    baseAddr <= fetchIn.addr;
                    lenReg   <= len4;
                    wordBuf  <= '0;
                end
            end else if ((state == stLoad || state == stFetch) && stage != '0) begin
                wordBuf <= loadWord;
            end
        end
    end

    // write strobe stays inside the latched store burst
    assert property (@(posedge clk) disable iff (rst)
        ram.rw |-> state == stStore && stage < lenBytes);

    assert property (@(posedge clk) disable iff (rst)
        dataOut.done |=> !dataOut.done);

    assert property (@(posedge clk) disable iff (rst)
        fetchOut.done |=> !fetchOut.done);

    // a held cycle leaves the sequencer exactly where it was
    assert property (@(posedge clk) disable iff (rst)
        hold |=> $stable(state) && $stable(stage));

endmodule

// ==== memPkg.sv ====
package memPkg;

    // bus widths
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;
    localparam int ByteWidth = 8;

    // bytes in one word or instruction
    localparam int WordBytes = DataWidth / ByteWidth;

    // byte stage counter runs 0..WordBytes
    localparam int StageWidth = 3;

    // instruction queue, depth must be a power of two
    localparam int QueueDepth = 4;
    localparam int QueuePtrWidth = $clog2(QueueDepth);
    localparam int QueueCntWidth = QueuePtrWidth + 1;

    typedef enum logic {
        cmdLoad,
        cmdStore
    } memCmd;

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore,
        stDone
    } ctrlState;

    // encoded as the byte count itself
    typedef enum logic [StageWidth-1:0] {
        len1 = 3'd1,
        len2 = 3'd2,
        len4 = 3'd4
    } accessLen;

    // data port, en is a level held until done
    typedef struct packed {
        logic                 en;
        memCmd                cmd;
        accessLen             len;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
    } dataReq;

    typedef struct packed {
        logic                 done;
        logic [DataWidth-1:0] rdata;
    } dataRsp;

    typedef struct packed {
        logic                 en;
        logic [AddrWidth-1:0] addr;
    } fetchReq;

    typedef struct packed {
        logic                 done;
        logic [DataWidth-1:0] inst;
    } fetchRsp;

    // rw high means write
    typedef struct packed {
        logic                 rw;
        logic [AddrWidth-1:0] addr;
        logic [ByteWidth-1:0] wdata;
    } ramBus;

    typedef struct packed {
        logic [AddrWidth-1:0] pc;
        logic [DataWidth-1:0] inst;
    } instEntry;

endpackage
